/* src/link_ctrl_pkg.sv */
////////////////////
// link controller shared definitions
// bus widths, address map, serial timing and bus fsm states
////////////////////
package link_ctrl_pkg;

  // bus and field widths
  localparam int IPB_ADDR_W = 24;
  localparam int IPB_DATA_W = 32;
  localparam int TGT_LSB    = 20;            // target nibble is addr[23:20]
  localparam int TGT_W      = 4;
  localparam int REG_IDX_W  = 2;             // addr[1:0] picks the register
  localparam int WR_COUNT_W = 16;
  localparam int BIT_IDX_W  = 5;

  // address map
  localparam int CHANNEL_COUNT = 5;          // targets 0 to 4
  localparam int SYNTH_TARGET  = 5;          // clock synth space

  // serial clock timing
  localparam int SCLK_HALF  = 2;             // ipb_clk cycles per dclk half period
  localparam int SYNTH_BITS = 32;            // one serial word
  localparam int SCLK_DIV_W = $clog2(SCLK_HALF);

  typedef logic [IPB_ADDR_W-1:0] ipb_addr_t;
  typedef logic [IPB_DATA_W-1:0] ipb_data_t;
  typedef logic [TGT_W-1:0]      target_t;
  typedef logic [REG_IDX_W-1:0]  reg_idx_t;
  typedef logic [WR_COUNT_W-1:0] wr_count_t;
  typedef logic [BIT_IDX_W-1:0]  bit_idx_t;

  // register indices
  localparam reg_idx_t CHAN_COUNT_REG = 2'd3;  // read-only write counter
  localparam reg_idx_t SYNTH_WORD_REG = 2'd0;  // word to launch
  localparam reg_idx_t SYNTH_STAT_REG = 2'd1;  // bit 0 busy
  localparam reg_idx_t SYNTH_CTRL_REG = 2'd2;  // goe, sync levels

  typedef enum logic [2:0] {
    st_idle,
    st_write,
    st_read,
    st_ack,
    st_hold
  } ipb_state_t;

endpackage

/* src/ipb_io_fsm.sv */
////////////////////
// bus slave state machine
// turns strobe and write level into one-cycle enables
// and returns a single ack per access
////////////////////
module ipb_io_fsm (
  input  logic ipb_clk,
  input  logic rst,
  input  logic ipb_strobe,  // master holds until ack
  input  logic ipb_write,
  input  logic io_rd_ack,   // registered mux ack
  output logic io_wr_en,
  output logic io_rd_en,
  output logic ipb_ack
);
  import link_ctrl_pkg::*;

  ipb_state_t state;
  ipb_state_t state_nxt;

  ////////////////////
  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (ipb_strobe) begin
          state_nxt = ipb_write ? st_write : st_read;
        end
      end
      st_write: begin
        state_nxt = st_ack;             // write lands with the enable
      end
      st_read: begin
        if (io_rd_ack) begin            // wait for the readback path
          state_nxt = st_ack;
        end
      end
      st_ack: begin
        state_nxt = st_hold;
      end
      st_hold: begin
        if (!ipb_strobe) begin          // master has let go
          state_nxt = st_idle;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  ////////////////////
  // state and enable flops
  always_ff @(posedge ipb_clk) begin
    if (rst) begin
      state    <= st_idle;
      io_wr_en <= 1'b0;
      io_rd_en <= 1'b0;
    end else begin
      state    <= state_nxt;
      io_wr_en <= (state == st_idle) && ipb_strobe && ipb_write;   // one cycle
      io_rd_en <= (state == st_idle) && ipb_strobe && !ipb_write;  // one cycle
    end
  end

  assign ipb_ack = (state == st_ack);   // single cycle by construction

endmodule

/* src/ipb_target_sel.sv */
////////////////////
// target decode and readback mux
// top address nibble picks a channel bank or the synth
////////////////////
module ipb_target_sel (
  input  logic ipb_clk,
  input  logic rst,
  input  link_ctrl_pkg::ipb_addr_t ipb_addr,
  input  logic io_wr_en,
  input  logic io_rd_en,
  output logic [link_ctrl_pkg::CHANNEL_COUNT-1:0] chan_wr,
  output logic [link_ctrl_pkg::CHANNEL_COUNT-1:0] chan_rd,
  output logic synth_wr,
  output logic synth_rd,
  input  logic [link_ctrl_pkg::CHANNEL_COUNT-1:0] chan_rd_ack,
  input  link_ctrl_pkg::ipb_data_t [link_ctrl_pkg::CHANNEL_COUNT-1:0] chan_rd_data,
  input  logic synth_rd_ack,
  input  link_ctrl_pkg::ipb_data_t synth_rd_data,
  output logic io_rd_ack,
  output link_ctrl_pkg::ipb_data_t ipb_rdata
);
  import link_ctrl_pkg::*;

  target_t target;
  logic [CHANNEL_COUNT-1:0] chan_sel;  // one-hot channel hit
  logic synth_sel;
  logic unmapped_rd;                   // read with nobody behind it
  logic rd_hit;
  ipb_data_t rd_mux;

  assign target = ipb_addr[TGT_LSB +: TGT_W];

  always_comb begin
    for (int i = 0; i < CHANNEL_COUNT; i++) begin
      chan_sel[i] = (target == target_t'(i));
    end
  end

  assign synth_sel = (target == target_t'(SYNTH_TARGET));
  assign chan_wr   = chan_sel & {CHANNEL_COUNT{io_wr_en}};
  assign chan_rd   = chan_sel & {CHANNEL_COUNT{io_rd_en}};
  assign synth_wr  = synth_sel & io_wr_en;
  assign synth_rd  = synth_sel & io_rd_en;

  ////////////////////
  // readback steering
  always_comb begin
    rd_mux = '0;                       // unmapped space reads zero
    if (synth_rd_ack) begin
      rd_mux = synth_rd_data;
    end
    for (int i = 0; i < CHANNEL_COUNT; i++) begin
      if (chan_rd_ack[i]) begin
        rd_mux = chan_rd_data[i];
      end
    end
  end

  assign rd_hit = (|chan_rd_ack) | synth_rd_ack | unmapped_rd;

  always_ff @(posedge ipb_clk) begin
    if (rst) begin
      unmapped_rd <= 1'b0;
      io_rd_ack   <= 1'b0;
    end else begin
      unmapped_rd <= io_rd_en && !synth_sel && !(|chan_sel);  // lines up with target acks
      io_rd_ack   <= rd_hit;
    end
  end

  always_ff @(posedge ipb_clk) begin
    if (rd_hit) begin
      ipb_rdata <= rd_mux;             // holds until next ack
    end
  end

endmodule

/* src/chan_reg_bank.sv */
////////////////////
// channel register bank
// three r/w words plus a count of accepted writes
////////////////////
module chan_reg_bank #(
  parameter int chan_index = 0         // bank number in the generate loop
) (
  input  logic ipb_clk,
  input  logic rst,
  input  logic wr,                     // one-cycle write strobe
  input  logic rd,                     // one-cycle read strobe
  input  link_ctrl_pkg::reg_idx_t reg_idx,
  input  link_ctrl_pkg::ipb_data_t wr_data,
  output link_ctrl_pkg::ipb_data_t rd_data,
  output logic rd_ack
);
  import link_ctrl_pkg::*;

  ipb_data_t reg0;
  ipb_data_t reg1;
  ipb_data_t reg2;
  wr_count_t wr_count;                 // writes to regs 0..2 only

  ////////////////////
  // write side
  always_ff @(posedge ipb_clk) begin
    if (rst) begin
      reg0     <= '0;
      reg1     <= '0;
      reg2     <= '0;
      wr_count <= '0;
    end else if (wr) begin
      case (reg_idx)
        2'd0:    reg0 <= wr_data;
        2'd1:    reg1 <= wr_data;
        2'd2:    reg2 <= wr_data;
        default: reg2 <= reg2;         // count reg, read only
      endcase
      if (reg_idx != CHAN_COUNT_REG) begin
        wr_count <= wr_count + wr_count_t'(1);
      end
    end
  end

  ////////////////////
  // registered readback
  always_ff @(posedge ipb_clk) begin
    if (rst) begin
      rd_ack <= 1'b0;
    end else begin
      rd_ack <= rd;
    end
  end

  always_ff @(posedge ipb_clk) begin
    if (rd) begin
      case (reg_idx)
        2'd0:    rd_data <= reg0;
        2'd1:    rd_data <= reg1;
        2'd2:    rd_data <= reg2;
        default: rd_data <= ipb_data_t'(wr_count);  // zero extended
      endcase
    end
  end

endmodule

/* src/synth_bit_timer.sv */
////////////////////
// serial clock synth bit timer
// half-period ticks and bit count for one word
////////////////////
module synth_bit_timer (
  input  logic ipb_clk,
  input  logic rst,
  input  logic start,                  // launch one word
  output logic half_tick,              // dclk edge due
  output logic last_bit,               // final bit in flight
  output logic busy
);
  import link_ctrl_pkg::*;

  logic [SCLK_DIV_W-1:0] div_cnt;      // ipb_clk cycles within a half period
  logic high_phase;                    // tracks dclk level
  bit_idx_t bit_idx;

  assign half_tick = busy && (div_cnt == SCLK_DIV_W'(SCLK_HALF - 1));
  assign last_bit  = busy && (bit_idx == bit_idx_t'(SYNTH_BITS - 1));

  always_ff @(posedge ipb_clk) begin
    if (rst) begin
      busy       <= 1'b0;
      div_cnt    <= '0;
      high_phase <= 1'b0;
      bit_idx    <= '0;
    end else if (start && !busy) begin
      busy       <= 1'b1;              // first half starts low
      div_cnt    <= '0;
      high_phase <= 1'b0;
      bit_idx    <= '0;
    end else if (busy) begin
      if (half_tick) begin
        div_cnt    <= '0;
        high_phase <= !high_phase;
        if (high_phase) begin          // falling edge closes a bit
          if (last_bit) begin
            busy <= 1'b0;              // done with dclk low
          end else begin
            bit_idx <= bit_idx + bit_idx_t'(1);
          end
        end
      end else begin
        div_cnt <= div_cnt + SCLK_DIV_W'(1);
      end
    end
  end

endmodule

/* src/synth_serial_if.sv */
////////////////////
// clock synth register target
// loads a 32-bit word and shifts it out on dclk, ddat, dlen
// with static goe and sync levels
////////////////////
module synth_serial_if (
  input  logic ipb_clk,
  input  logic rst,
  input  logic wr,
  input  logic rd,
  input  link_ctrl_pkg::reg_idx_t reg_idx,
  input  link_ctrl_pkg::ipb_data_t wr_data,
  output link_ctrl_pkg::ipb_data_t rd_data,
  output logic rd_ack,
  input  logic half_tick,
  input  logic last_bit,
  input  logic busy,
  output logic start,
  output logic dclk,
  output logic ddat,
  output logic dlen,
  output logic goe,
  output logic sync
);
  import link_ctrl_pkg::*;

  ipb_data_t last_word;                // register 0
  ipb_data_t shift_q;                  // msb drives ddat
  logic load;

  assign load  = wr && (reg_idx == SYNTH_WORD_REG) && !busy;  // ignored while busy
  assign start = load;
  assign ddat  = shift_q[SYNTH_BITS-1];

  ////////////////////
  // shifter and pins
  always_ff @(posedge ipb_clk) begin
    if (rst) begin
      last_word <= '0;
      shift_q   <= '0;
      dclk      <= 1'b0;
      dlen      <= 1'b0;
      goe       <= 1'b0;
      sync      <= 1'b0;
    end else begin
      if (load) begin
        last_word <= wr_data;
        shift_q   <= wr_data;          // bit 31 out first
        dclk      <= 1'b0;
        dlen      <= 1'b1;
      end else if (half_tick) begin
        dclk <= !dclk;
        if (dclk) begin                // falling edge, next bit
          shift_q <= shift_q << 1;
          if (last_bit) begin
            dlen <= 1'b0;
          end
        end
      end
      if (wr && (reg_idx == SYNTH_CTRL_REG)) begin
        goe  <= wr_data[0];
        sync <= wr_data[1];
      end
    end
  end

  ////////////////////
  // registered readback
  always_ff @(posedge ipb_clk) begin
    if (rst) begin
      rd_ack <= 1'b0;
    end else begin
      rd_ack <= rd;
    end
  end

  always_ff @(posedge ipb_clk) begin
    if (rd) begin
      case (reg_idx)
        SYNTH_WORD_REG: rd_data <= last_word;
        SYNTH_STAT_REG: rd_data <= ipb_data_t'(busy);
        SYNTH_CTRL_REG: rd_data <= ipb_data_t'({sync, goe});
        default:        rd_data <= '0;
      endcase
    end
  end

endmodule

/* src/link_ctrl_top.sv */
////////////////////
// link controller bus side top level
// bus fsm, target decode, five channel banks, clock synth
////////////////////
module link_ctrl_top (
  input  logic ipb_clk,
  input  logic rst,
  input  logic ipb_strobe,
  input  logic ipb_write,
  input  link_ctrl_pkg::ipb_addr_t ipb_addr,
  input  link_ctrl_pkg::ipb_data_t ipb_wdata,
  output link_ctrl_pkg::ipb_data_t ipb_rdata,
  output logic ipb_ack,
  output logic adcclk_dclk,
  output logic adcclk_ddat,
  output logic adcclk_dlen,
  output logic adcclk_goe,
  output logic adcclk_sync
);
  import link_ctrl_pkg::*;

  logic io_wr_en;
  logic io_rd_en;
  logic io_rd_ack;                     // from the readback mux
  logic [CHANNEL_COUNT-1:0] chan_wr;
  logic [CHANNEL_COUNT-1:0] chan_rd;
  logic [CHANNEL_COUNT-1:0] chan_rd_ack;
  ipb_data_t [CHANNEL_COUNT-1:0] chan_rd_data;
  logic synth_wr;
  logic synth_rd;
  logic synth_rd_ack;
  ipb_data_t synth_rd_data;
  logic half_tick;
  logic last_bit;
  logic busy;
  logic start;

  ipb_io_fsm i_ipb_io_fsm (
    .ipb_clk   (ipb_clk),
    .rst       (rst),
    .ipb_strobe(ipb_strobe),
    .ipb_write (ipb_write),
    .io_rd_ack (io_rd_ack),
    .io_wr_en  (io_wr_en),
    .io_rd_en  (io_rd_en),
    .ipb_ack   (ipb_ack)
  );

  ipb_target_sel i_ipb_target_sel (
    .ipb_clk      (ipb_clk),
    .rst          (rst),
    .ipb_addr     (ipb_addr),
    .io_wr_en     (io_wr_en),
    .io_rd_en     (io_rd_en),
    .chan_wr      (chan_wr),
    .chan_rd      (chan_rd),
    .synth_wr     (synth_wr),
    .synth_rd     (synth_rd),
    .chan_rd_ack  (chan_rd_ack),
    .chan_rd_data (chan_rd_data),
    .synth_rd_ack (synth_rd_ack),
    .synth_rd_data(synth_rd_data),
    .io_rd_ack    (io_rd_ack),
    .ipb_rdata    (ipb_rdata)
  );

  ////////////////////
  // channel banks, one per target nibble 0..4
  for (genvar i = 0; i < CHANNEL_COUNT; i++) begin : g_chan
    chan_reg_bank #(
      .chan_index(i)
    ) i_chan_reg_bank (
      .ipb_clk(ipb_clk),
      .rst    (rst),
      .wr     (chan_wr[i]),
      .rd     (chan_rd[i]),
      .reg_idx(ipb_addr[REG_IDX_W-1:0]),
      .wr_data(ipb_wdata),
      .rd_data(chan_rd_data[i]),
      .rd_ack (chan_rd_ack[i])
    );
  end

  ////////////////////
  // clock synth
  synth_bit_timer i_synth_bit_timer (
    .ipb_clk  (ipb_clk),
    .rst      (rst),
    .start    (start),
    .half_tick(half_tick),
    .last_bit (last_bit),
    .busy     (busy)
  );

  synth_serial_if i_synth_serial_if (
    .ipb_clk  (ipb_clk),
    .rst      (rst),
    .wr       (synth_wr),
    .rd       (synth_rd),
    .reg_idx  (ipb_addr[REG_IDX_W-1:0]),
    .wr_data  (ipb_wdata),
    .rd_data  (synth_rd_data),
    .rd_ack   (synth_rd_ack),
    .half_tick(half_tick),
    .last_bit (last_bit),
    .busy     (busy),
    .start    (start),
    .dclk     (adcclk_dclk),
    .ddat     (adcclk_ddat),
    .dlen     (adcclk_dlen),
    .goe      (adcclk_goe),
    .sync     (adcclk_sync)
  );

endmodule

/* dv/tb_clk_gen.sv */
////////////////////
// testbench clock and reset source
////////////////////
module tb_clk_gen #(
  parameter int period     = 20,       // time units per clock
  parameter int rst_cycles = 2
) (
  output logic ipb_clk,
  output logic rst
);

  initial begin
    ipb_clk = 1'b0;
    forever #(period / 2) ipb_clk = ~ipb_clk;
  end

  initial begin
    rst = 1'b1;                        // held from time zero
    repeat (rst_cycles) @(posedge ipb_clk);
    rst <= 1'b0;
  end

endmodule

/* dv/tb_link_ctrl_top.sv */
////////////////////
// link controller testbench
// runs the bus operations of the stimulus file against the DUT
// and watches the serial clock synth pins
////////////////////
module tb_link_ctrl_top;
  import link_ctrl_pkg::*;

  localparam string stimulus_path   = "dv/link_ctrl_stimulus.txt";
  localparam int    ack_wait_limit  = 20;   // bus access cycles
  localparam int    serial_wait_lim = 200;  // cycles for one serial word
  localparam logic [3:0] synth_nibble = 4'h5;

  logic      ipb_clk;
  logic      rst;
  logic      ipb_strobe;
  logic      ipb_write;
  ipb_addr_t ipb_addr;
  ipb_data_t ipb_wdata;
  ipb_data_t ipb_rdata;
  logic      ipb_ack;
  logic      adcclk_dclk;
  logic      adcclk_ddat;
  logic      adcclk_dlen;
  logic      adcclk_goe;
  logic      adcclk_sync;

  logic [7:0]  op_q[$];                // W, R or S per line
  logic [31:0] addr_q[$];
  logic [31:0] val_q[$];               // write data or expected value
  logic [31:0] serial_q[$];            // words seen on the pins
  int bus_lines = 0;
  int serial_lines = 0;
  int error_count = 0;
  int failed_tests = 0;
  int cycle_count = 0;
  int cycle_limit = 0;                 // zero until the file is read

  logic [31:0] shift_word = '0;
  int          bit_count = 0;
  logic        dclk_prev = 1'b0;

  tb_clk_gen #(.period(20), .rst_cycles(2)) i_tb_clk_gen (
    .ipb_clk(ipb_clk),
    .rst    (rst)
  );

  link_ctrl_top i_link_ctrl_top (
    .ipb_clk    (ipb_clk),
    .rst        (rst),
    .ipb_strobe (ipb_strobe),
    .ipb_write  (ipb_write),
    .ipb_addr   (ipb_addr),
    .ipb_wdata  (ipb_wdata),
    .ipb_rdata  (ipb_rdata),
    .ipb_ack    (ipb_ack),
    .adcclk_dclk(adcclk_dclk),
    .adcclk_ddat(adcclk_ddat),
    .adcclk_dlen(adcclk_dlen),
    .adcclk_goe (adcclk_goe),
    .adcclk_sync(adcclk_sync)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  // reads one operation per line and skips '#' note lines
  task automatic load_stimulus(output logic ok);
    int fd;
    int c;
    int n;
    logic [7:0] ch;
    logic [31:0] f1;
    logic [31:0] f2;
    ok = 1'b0;
    fd = $fopen(stimulus_path, "r");
    if (fd != 0) begin
      ok = 1'b1;
      c = $fgetc(fd);
      while (c >= 0) begin
        ch = c[7:0];
        if (ch == "#") begin
          while (c >= 0 && c[7:0] != 8'h0a) c = $fgetc(fd);  // skip to end of line
        end else if (ch == "W" || ch == "R") begin
          n = $fscanf(fd, "%h %h", f1, f2);
          if (n != 2) ok = 1'b0;
          op_q.push_back(ch);
          addr_q.push_back(f1);
          val_q.push_back(f2);
          bus_lines++;
        end else if (ch == "S") begin
          n = $fscanf(fd, "%h", f2);
          if (n != 1) ok = 1'b0;
          op_q.push_back(ch);
          addr_q.push_back('0);           // no address for a serial word
          val_q.push_back(f2);
          serial_lines++;
        end else if (ch != " " && ch != "\t" && ch != "\n" && ch != "\r") begin
          ok = 1'b0;                      // stray text
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
  endtask

  // full strobe and ack cycle with the strobe dropped after the ack
  task automatic bus_access(input logic is_write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic acked);
    int waited;
    waited = 0;
    acked = 1'b0;
    rdata = '0;
    @(posedge ipb_clk);
    ipb_strobe <= 1'b1;
    ipb_write  <= is_write;
    ipb_addr   <= addr[23:0];
    ipb_wdata  <= wdata;
    while (!acked && waited < ack_wait_limit) begin
      @(negedge ipb_clk);              // ack and data settled mid-cycle
      if (ipb_ack) begin
        acked = 1'b1;
        rdata = ipb_rdata;
      end
      waited++;
    end
    @(posedge ipb_clk);
    ipb_strobe <= 1'b0;
  endtask

  // word is complete once dlen has dropped again
  task automatic wait_serial(input string name, input logic [31:0] expected);
    int waited;
    waited = 0;
    while ((serial_q.size() == 0 || adcclk_dlen) && waited < serial_wait_lim) begin
      @(negedge ipb_clk);
      waited++;
    end
    if (serial_q.size() == 0) begin
      $display("%s: no serial word arrived within %0d cycles", name, serial_wait_lim);
      error_count++;
    end else begin
      check_value(name, expected, serial_q.pop_front());
      if (adcclk_dlen || adcclk_dclk) begin
        $display("%s: dlen or dclk still high after the serial word", name);
        error_count++;
      end
    end
  endtask

  task automatic run_test(input int idx);
    string name;
    logic [31:0] addr;
    logic [31:0] val;
    logic [31:0] rdata;
    logic acked;
    int errors_before;
    addr = addr_q[idx];
    val = val_q[idx];
    name = $sformatf("t%0d_%c_%h", idx, op_q[idx], addr[23:0]);
    errors_before = error_count;
    case (op_q[idx])
      "W": begin
        bus_access(1'b1, addr, val, rdata, acked);
        if (!acked) begin
          $display("%s: write got no ack from the DUT", name);
          error_count++;
        end else if (addr[23:20] == synth_nibble && addr[1:0] == 2'd2) begin
          // control write lands on the pins with the ack
          check_value({name, "_pins"}, {30'd0, val[1:0]}, {30'd0, adcclk_sync, adcclk_goe});
        end
      end
      "R": begin
        bus_access(1'b0, addr, '0, rdata, acked);
        if (!acked) begin
          $display("%s: read got no ack from the DUT", name);
          error_count++;
        end else begin
          check_value(name, val, rdata);
        end
      end
      default: begin
        wait_serial(name, val);
      end
    endcase
    if (error_count == errors_before) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s", name);
      failed_tests++;
    end
  endtask

  ////////////////////
  // serial monitor assembling msb first on each dclk rise
  always @(negedge ipb_clk) begin
    if (rst || !adcclk_dlen) begin
      shift_word <= '0;
      bit_count  <= 0;
    end else if (adcclk_dclk && !dclk_prev) begin
      shift_word <= {shift_word[30:0], adcclk_ddat};
      if (bit_count == 31) begin
        serial_q.push_back({shift_word[30:0], adcclk_ddat});
        bit_count <= 0;
      end else begin
        bit_count <= bit_count + 1;
      end
    end
    dclk_prev <= adcclk_dclk;
  end

  ////////////////////
  // run limit
  always @(posedge ipb_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    logic ok;
    ipb_strobe = 1'b0;
    ipb_write  = 1'b0;
    ipb_addr   = '0;
    ipb_wdata  = '0;
    load_stimulus(ok);
    if (!ok) begin
      $display("could not read a valid %s", stimulus_path);
      $display("Done: errors found");
      $finish;
    end else begin
      cycle_limit = 10 * bus_lines + 200 * serial_lines + 50;
      while (rst) @(posedge ipb_clk);
      @(posedge ipb_clk);
      for (int i = 0; i < op_q.size(); i++) begin
        run_test(i);
      end
      if (serial_q.size() != 0) begin
        $display("%0d serial word(s) seen that no test expected", serial_q.size());
        error_count++;
      end
      $display("tests: %0d, failed: %0d, check errors: %0d",
               op_q.size(), failed_tests, error_count);
      if (error_count == 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

endmodule

/* Makefile */
# Verilator build and run for the link controller bus side
# pass or fail is taken from the testbench output

VERILATOR ?= verilator
TOP       ?= tb_link_ctrl_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim.f */
src/link_ctrl_pkg.sv
src/ipb_io_fsm.sv
src/ipb_target_sel.sv
src/chan_reg_bank.sv
src/synth_bit_timer.sv
src/synth_serial_if.sv
src/link_ctrl_top.sv
dv/tb_clk_gen.sv
dv/tb_link_ctrl_top.sv

/* dv/link_ctrl_stimulus.txt */
# op addr value : W addr data = write, R addr expected = read and compare
# S expected = wait for one serial word; hex fields, addr[23:20] is the target
# distinct words into registers 0 to 2 of every channel
W 000000 a0503c96
W 000001 a0513c96
W 000002 a0523c96
W 100000 a1503c96
W 100001 a1513c96
W 100002 a1523c96
W 200000 a2503c96
W 200001 a2513c96
W 200002 a2523c96
W 300000 a3503c96
W 300001 a3513c96
W 300002 a3523c96
W 400000 a4503c96
W 400001 a4513c96
W 400002 a4523c96
R 000000 a0503c96
R 000001 a0513c96
R 000002 a0523c96
R 100000 a1503c96
R 100001 a1513c96
R 100002 a1523c96
R 200000 a2503c96
R 200001 a2513c96
R 200002 a2523c96
R 300000 a3503c96
R 300001 a3513c96
R 300002 a3523c96
R 400000 a4503c96
R 400001 a4513c96
R 400002 a4523c96
# channel 3 write counter, register 3 is read only
R 300003 00000003
W 300000 ffffffff
W 300001 00000000
R 300003 00000005
W 300003 12345678
R 300003 00000005
R 300000 ffffffff
# unmapped targets read zero
R 900000 00000000
R f00001 00000000
# one serial word, busy during and after
W 500000 c3a51e7f
R 500001 00000001
S c3a51e7f
R 500001 00000000
R 500000 c3a51e7f
# second launch while busy is dropped
W 500000 0f1e2d3c
W 500000 ffff0000
R 500000 0f1e2d3c
S 0f1e2d3c
R 500000 0f1e2d3c
R 500001 00000000
# goe and sync levels
W 500002 00000001
R 500002 00000001
W 500002 00000002
R 500002 00000002
W 500002 00000000
R 500002 00000000
